//--- hdl/csr_settings.svh
// Machine and user mode only, so supervisor, performance counter and extension CSRs do not exist
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define CSR_XLEN 32

// Machine trap setup
`define CSR_MSTATUS_ADDR       12'h300
`define CSR_MISA_ADDR          12'h301
`define CSR_MIE_ADDR           12'h304
`define CSR_MTVEC_ADDR         12'h305
`define CSR_MCOUNTEREN_ADDR    12'h306
`define CSR_MSTATUSH_ADDR      12'h310
`define CSR_MCOUNTINHIBIT_ADDR 12'h320

// Machine trap handling
`define CSR_MSCRATCH_ADDR      12'h340
`define CSR_MEPC_ADDR          12'h341
`define CSR_MCAUSE_ADDR        12'h342
`define CSR_MTVAL_ADDR         12'h343
`define CSR_MIP_ADDR           12'h344

// Machine counters
`define CSR_MCYCLE_ADDR        12'hB00
`define CSR_MINSTRET_ADDR      12'hB02
`define CSR_MCYCLEH_ADDR       12'hB80
`define CSR_MINSTRETH_ADDR     12'hB82

// User read-only counter views
`define CSR_CYCLE_ADDR         12'hC00
`define CSR_TIME_ADDR          12'hC01
`define CSR_INSTRET_ADDR       12'hC02
`define CSR_CYCLEH_ADDR        12'hC80
`define CSR_TIMEH_ADDR         12'hC81
`define CSR_INSTRETH_ADDR      12'hC82

// Machine information
`define CSR_MVENDORID_ADDR     12'hF11
`define CSR_MARCHID_ADDR       12'hF12
`define CSR_MIMPID_ADDR        12'hF13
`define CSR_MHARTID_ADDR       12'hF14
`define CSR_MCONFIGPTR_ADDR    12'hF15

`define CSR_MSTATUS_MASK       32'h0022_1888  // mie, mpie, mpp, mprv, tw
`define CSR_INT_MASK           32'h0000_0888  // msi, mti, mei
`define CSR_MSTATUS_RESET      32'h0020_0000  // tw set, mpp in user mode
`define CSR_MCOUNTEREN_RESET   3'b111
`define CSR_MISA_VALUE         32'h4010_0100  // RV32 base with I and U
`define CSR_HART_ID            0

`endif

//--- hdl/csr_pkg.sv
// Status layout holds only the M and U mode fields; sd, fs, vs, xs and supervisor bits read zero
`include "csr_settings.svh"

package csr_pkg;

  typedef enum logic [1:0] {
    U_MODE        = 2'd0,
    S_MODE        = 2'd1,
    RESERVED_MODE = 2'd2,
    M_MODE        = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } vector_mode_t;

  // Bit 31 down to bit 0
  typedef struct packed {
    logic [9:0]  reserved_31_22;
    logic        tw;
    logic [2:0]  reserved_20_18;
    logic        mprv;
    logic [3:0]  reserved_16_13;
    priv_level_t mpp;
    logic [2:0]  reserved_10_8;
    logic        mpie;
    logic [2:0]  reserved_6_4;
    logic        mie;
    logic [2:0]  reserved_2_0;
  } mstatus_fields_t;

  // Same word seen raw or as mstatus fields
  typedef union packed {
    logic [`CSR_XLEN-1:0] raw;
    mstatus_fields_t      status;
  } csr_word_u;

endpackage

//--- hdl/csr_access.sv
// Combinational only; csr_write, csr_set and csr_clear must be one-hot or all low
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_access import csr_pkg::*; (
  input  logic [11:0]          csr_addr,
  input  logic                 csr_write,
  input  logic                 csr_set,
  input  logic                 csr_clear,
  input  logic                 csr_read_only,
  input  logic                 valid_write,
  input  priv_level_t          curr_priv,
  input  logic [`CSR_XLEN-1:0] new_csr_val,
  input  logic [`CSR_XLEN-1:0] read_val,
  output csr_word_u            wr_val,
  output logic                 commit,
  output logic                 priv_fault
);

  logic csr_op;
  logic ro_violation;
  logic priv_violation;

  assign csr_op = csr_write | csr_set | csr_clear;

  // Top address bits 11 mark a read-only CSR
  assign ro_violation   = (csr_addr[11:10] == 2'b11) & ~csr_read_only;
  assign priv_violation = csr_addr[9:8] > curr_priv;  // Lowest privilege allowed
  assign priv_fault     = csr_op & (ro_violation | priv_violation);

  // Read-modify-write value
  always_comb begin
    if (csr_set) begin
      wr_val.raw = read_val | new_csr_val;
    end else if (csr_clear) begin
      wr_val.raw = read_val & ~new_csr_val;
    end else begin
      wr_val.raw = new_csr_val;  // Plain write
    end
  end

  // Faulting accesses never reach the registers
  assign commit = valid_write & csr_op & ~priv_fault;

endmodule

//--- hdl/csr_trap_regs.sv
// Software writes are WARL legalized; an injection wins over a same-cycle write to its register
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_trap_regs import csr_pkg::*; (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic [11:0]          csr_addr,
  input  logic                 commit,
  input  csr_word_u            wr_val,
  input  logic                 inject_mstatus,
  input  logic                 inject_mepc,
  input  logic                 inject_mcause,
  input  logic                 inject_mtval,
  input  logic                 inject_mip,
  input  csr_word_u            next_mstatus,
  input  logic [`CSR_XLEN-1:0] next_mepc,
  input  logic [`CSR_XLEN-1:0] next_mcause,
  input  logic [`CSR_XLEN-1:0] next_mtval,
  input  logic [`CSR_XLEN-1:0] next_mip,
  output logic [`CSR_XLEN-1:0] curr_mstatus,
  output logic [`CSR_XLEN-1:0] curr_mtvec,
  output logic [`CSR_XLEN-1:0] curr_mie,
  output logic [`CSR_XLEN-1:0] curr_mip,
  output logic [`CSR_XLEN-1:0] curr_mepc,
  output logic [`CSR_XLEN-1:0] curr_mcause,
  output logic [`CSR_XLEN-1:0] mtval,
  output logic [`CSR_XLEN-1:0] mscratch,
  output logic [2:0]           mcounteren,
  output logic [2:0]           mcountinhibit
);

  mstatus_fields_t      mstatus_q, mstatus_d;
  logic [`CSR_XLEN-3:0] mtvec_base_q, mtvec_base_d;
  vector_mode_t         mtvec_mode_q, mtvec_mode_d;
  logic [`CSR_XLEN-1:0] mie_d, mip_d, mepc_d, mcause_d, mtval_d, mscratch_d;
  logic [2:0]           mcounteren_d, mcountinhibit_d;

  // Keep the field bits only and fold unsupported mpp values to user mode
  function automatic mstatus_fields_t legal_status(input csr_word_u w);
    mstatus_fields_t s;
    s = mstatus_fields_t'(w.raw & `CSR_MSTATUS_MASK);
    if (w.status.mpp == S_MODE || w.status.mpp == RESERVED_MODE) begin
      s.mpp = U_MODE;
    end
    return s;
  endfunction

  always_comb begin
    mstatus_d       = mstatus_q;
    mtvec_base_d    = mtvec_base_q;
    mtvec_mode_d    = mtvec_mode_q;
    mie_d           = curr_mie;
    mip_d           = curr_mip;
    mepc_d          = curr_mepc;
    mcause_d        = curr_mcause;
    mtval_d         = mtval;
    mscratch_d      = mscratch;
    mcounteren_d    = mcounteren;
    mcountinhibit_d = mcountinhibit;

    if (commit) begin
      case (csr_addr)
        `CSR_MSTATUS_ADDR:       mstatus_d = legal_status(wr_val);
        `CSR_MTVEC_ADDR: begin
          mtvec_base_d = wr_val.raw[`CSR_XLEN-1:2];
          // Modes 2 and 3 are reserved
          mtvec_mode_d = (wr_val.raw[1:0] > 2'b01) ? DIRECT : vector_mode_t'(wr_val.raw[1:0]);
        end
        `CSR_MIE_ADDR:           mie_d = wr_val.raw & `CSR_INT_MASK;
        `CSR_MIP_ADDR:           mip_d = wr_val.raw & `CSR_INT_MASK;
        `CSR_MSCRATCH_ADDR:      mscratch_d = wr_val.raw;
        `CSR_MEPC_ADDR:          mepc_d = wr_val.raw;
        `CSR_MCAUSE_ADDR:        mcause_d = wr_val.raw;
        `CSR_MTVAL_ADDR:         mtval_d = wr_val.raw;
        `CSR_MCOUNTEREN_ADDR:    mcounteren_d = wr_val.raw[2:0];  // cy, tm, ir
        `CSR_MCOUNTINHIBIT_ADDR: mcountinhibit_d = {wr_val.raw[2], 1'b0, wr_val.raw[0]};
        default: ;
      endcase
    end

    // Trap logic has the last word
    if (inject_mstatus) begin
      mstatus_d = legal_status(next_mstatus);
    end
    if (inject_mepc) begin
      mepc_d = next_mepc;
    end
    if (inject_mcause) begin
      mcause_d = next_mcause;
    end
    if (inject_mtval) begin
      mtval_d = next_mtval;
    end
    if (inject_mip) begin
      mip_d = next_mip;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_q     <= mstatus_fields_t'(`CSR_MSTATUS_RESET);
      mtvec_base_q  <= '0;
      mtvec_mode_q  <= DIRECT;
      curr_mie      <= '0;
      curr_mip      <= '0;
      curr_mepc     <= '0;
      curr_mcause   <= '0;
      mtval         <= '0;
      mscratch      <= '0;
      mcounteren    <= `CSR_MCOUNTEREN_RESET;
      mcountinhibit <= '0;
    end else begin
      mstatus_q     <= mstatus_d;
      mtvec_base_q  <= mtvec_base_d;
      mtvec_mode_q  <= mtvec_mode_d;
      curr_mie      <= mie_d;
      curr_mip      <= mip_d;
      curr_mepc     <= mepc_d;
      curr_mcause   <= mcause_d;
      mtval         <= mtval_d;
      mscratch      <= mscratch_d;
      mcounteren    <= mcounteren_d;
      mcountinhibit <= mcountinhibit_d;
    end
  end

  assign curr_mstatus = mstatus_q;
  assign curr_mtvec   = {mtvec_base_q, mtvec_mode_q};

endmodule

//--- hdl/csr_counters.sv
// Counters wrap at 64 bits; a software load of one half replaces that cycle's increment
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_counters (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic [11:0]          csr_addr,
  input  logic                 commit,
  input  logic [`CSR_XLEN-1:0] wr_val,
  input  logic                 inst_ret,
  input  logic [2:0]           mcountinhibit,
  output logic [63:0]          mcycle_full,
  output logic [63:0]          minstret_full
);

  logic [63:0] mcycle_d;
  logic [63:0] minstret_d;

  // Shared by both counters
  function automatic logic [63:0] count_next(
    input logic [63:0]          cnt,
    input logic                 inc,
    input logic                 load_lo,
    input logic                 load_hi,
    input logic [`CSR_XLEN-1:0] val
  );
    logic [63:0] res;
    res = cnt + 64'(inc);
    if (load_lo) begin
      res = {cnt[63:32], val};
    end else if (load_hi) begin
      res = {val, cnt[31:0]};
    end
    return res;
  endfunction

  always_comb begin
    mcycle_d   = count_next(mcycle_full, ~mcountinhibit[0],
                            commit && (csr_addr == `CSR_MCYCLE_ADDR),
                            commit && (csr_addr == `CSR_MCYCLEH_ADDR), wr_val);
    minstret_d = count_next(minstret_full, ~mcountinhibit[2] & inst_ret,
                            commit && (csr_addr == `CSR_MINSTRET_ADDR),
                            commit && (csr_addr == `CSR_MINSTRETH_ADDR), wr_val);
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mcycle_full   <= '0;
      minstret_full <= '0;
    end else begin
      mcycle_full   <= mcycle_d;
      minstret_full <= minstret_d;
    end
  end

endmodule

//--- hdl/csr_read_mux.sv
// Combinational read path; information CSRs are constants and time comes from the external mtime
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_read_mux import csr_pkg::*; #(
  parameter int HART_ID = `CSR_HART_ID
) (
  input  logic [11:0]          csr_addr,
  input  logic                 csr_write,
  input  logic                 csr_set,
  input  logic                 csr_clear,
  input  priv_level_t          curr_priv,
  input  logic [`CSR_XLEN-1:0] curr_mstatus,
  input  logic [`CSR_XLEN-1:0] curr_mtvec,
  input  logic [`CSR_XLEN-1:0] curr_mie,
  input  logic [`CSR_XLEN-1:0] curr_mip,
  input  logic [`CSR_XLEN-1:0] curr_mepc,
  input  logic [`CSR_XLEN-1:0] curr_mcause,
  input  logic [`CSR_XLEN-1:0] mtval,
  input  logic [`CSR_XLEN-1:0] mscratch,
  input  logic [2:0]           mcounteren,
  input  logic [2:0]           mcountinhibit,
  input  logic [63:0]          mcycle_full,
  input  logic [63:0]          minstret_full,
  input  logic [63:0]          mtime,
  output logic [`CSR_XLEN-1:0] read_val,
  output logic                 addr_fault
);

  logic                 csr_op;
  logic                 user_mode;
  logic                 cnt_denied;   // User counter hidden by mcounteren
  logic                 implemented;
  logic [`CSR_XLEN-1:0] raw_val;

  assign csr_op    = csr_write | csr_set | csr_clear;
  assign user_mode = (curr_priv == U_MODE);

  always_comb begin
    case (csr_addr)
      `CSR_CYCLE_ADDR, `CSR_CYCLEH_ADDR:     cnt_denied = user_mode & ~mcounteren[0];
      `CSR_TIME_ADDR, `CSR_TIMEH_ADDR:       cnt_denied = user_mode & ~mcounteren[1];
      `CSR_INSTRET_ADDR, `CSR_INSTRETH_ADDR: cnt_denied = user_mode & ~mcounteren[2];
      default:                               cnt_denied = 1'b0;
    endcase
  end

  always_comb begin
    raw_val     = '0;
    implemented = 1'b1;
    case (csr_addr)
      `CSR_MVENDORID_ADDR, `CSR_MARCHID_ADDR, `CSR_MIMPID_ADDR,
      `CSR_MCONFIGPTR_ADDR, `CSR_MSTATUSH_ADDR: raw_val = '0;  // Little endian, no IDs
      `CSR_MHARTID_ADDR:       raw_val = HART_ID;
      `CSR_MISA_ADDR:          raw_val = `CSR_MISA_VALUE;
      `CSR_MSTATUS_ADDR:       raw_val = curr_mstatus;
      `CSR_MTVEC_ADDR:         raw_val = curr_mtvec;
      `CSR_MIE_ADDR:           raw_val = curr_mie;
      `CSR_MIP_ADDR:           raw_val = curr_mip;
      `CSR_MSCRATCH_ADDR:      raw_val = mscratch;
      `CSR_MEPC_ADDR:          raw_val = curr_mepc;
      `CSR_MCAUSE_ADDR:        raw_val = curr_mcause;
      `CSR_MTVAL_ADDR:         raw_val = mtval;
      `CSR_MCOUNTEREN_ADDR:    raw_val = {{(`CSR_XLEN-3){1'b0}}, mcounteren};
      `CSR_MCOUNTINHIBIT_ADDR: raw_val = {{(`CSR_XLEN-3){1'b0}}, mcountinhibit};
      `CSR_MCYCLE_ADDR, `CSR_CYCLE_ADDR:       raw_val = mcycle_full[31:0];
      `CSR_MCYCLEH_ADDR, `CSR_CYCLEH_ADDR:     raw_val = mcycle_full[63:32];
      `CSR_MINSTRET_ADDR, `CSR_INSTRET_ADDR:   raw_val = minstret_full[31:0];
      `CSR_MINSTRETH_ADDR, `CSR_INSTRETH_ADDR: raw_val = minstret_full[63:32];
      `CSR_TIME_ADDR:          raw_val = mtime[31:0];
      `CSR_TIMEH_ADDR:         raw_val = mtime[63:32];
      default:                 implemented = 1'b0;
    endcase
  end

  assign read_val   = cnt_denied ? '0 : raw_val;
  assign addr_fault = csr_op & (~implemented | cnt_denied);

endmodule

//--- hdl/csr_file.sv
// Machine-mode CSR file for an M and U mode RV32 core; reads and faults are same-cycle
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_file import csr_pkg::*; #(
  parameter int HART_ID = `CSR_HART_ID
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic [11:0]          csr_addr,
  input  logic                 csr_write,
  input  logic                 csr_set,
  input  logic                 csr_clear,
  input  logic                 csr_read_only,
  input  logic                 valid_write,
  input  logic [`CSR_XLEN-1:0] new_csr_val,
  input  priv_level_t          curr_priv,
  input  logic                 inst_ret,
  input  logic [63:0]          mtime,
  input  logic                 inject_mstatus,
  input  logic                 inject_mepc,
  input  logic                 inject_mcause,
  input  logic                 inject_mtval,
  input  logic                 inject_mip,
  input  csr_word_u            next_mstatus,
  input  logic [`CSR_XLEN-1:0] next_mepc,
  input  logic [`CSR_XLEN-1:0] next_mcause,
  input  logic [`CSR_XLEN-1:0] next_mtval,
  input  logic [`CSR_XLEN-1:0] next_mip,
  output logic [`CSR_XLEN-1:0] old_csr_val,
  output logic                 invalid_csr,
  output logic [`CSR_XLEN-1:0] curr_mstatus,
  output logic [`CSR_XLEN-1:0] curr_mtvec,
  output logic [`CSR_XLEN-1:0] curr_mie,
  output logic [`CSR_XLEN-1:0] curr_mip,
  output logic [`CSR_XLEN-1:0] curr_mepc,
  output logic [`CSR_XLEN-1:0] curr_mcause
);

  csr_word_u            wr_val;
  logic                 commit;
  logic                 priv_fault;
  logic                 addr_fault;
  logic [`CSR_XLEN-1:0] mtval;
  logic [`CSR_XLEN-1:0] mscratch;
  logic [2:0]           mcounteren;
  logic [2:0]           mcountinhibit;
  logic [63:0]          mcycle_full;
  logic [63:0]          minstret_full;

  assign invalid_csr = priv_fault | addr_fault;

  // Read value feeds back for set and clear
  csr_access u_access (
    .csr_addr     (csr_addr),
    .csr_write    (csr_write),
    .csr_set      (csr_set),
    .csr_clear    (csr_clear),
    .csr_read_only(csr_read_only),
    .valid_write  (valid_write),
    .curr_priv    (curr_priv),
    .new_csr_val  (new_csr_val),
    .read_val     (old_csr_val),
    .wr_val       (wr_val),
    .commit       (commit),
    .priv_fault   (priv_fault)
  );

  csr_trap_regs u_trap_regs (
    .CLK           (CLK),
    .nRST          (nRST),
    .csr_addr      (csr_addr),
    .commit        (commit),
    .wr_val        (wr_val),
    .inject_mstatus(inject_mstatus),
    .inject_mepc   (inject_mepc),
    .inject_mcause (inject_mcause),
    .inject_mtval  (inject_mtval),
    .inject_mip    (inject_mip),
    .next_mstatus  (next_mstatus),
    .next_mepc     (next_mepc),
    .next_mcause   (next_mcause),
    .next_mtval    (next_mtval),
    .next_mip      (next_mip),
    .curr_mstatus  (curr_mstatus),
    .curr_mtvec    (curr_mtvec),
    .curr_mie      (curr_mie),
    .curr_mip      (curr_mip),
    .curr_mepc     (curr_mepc),
    .curr_mcause   (curr_mcause),
    .mtval         (mtval),
    .mscratch      (mscratch),
    .mcounteren    (mcounteren),
    .mcountinhibit (mcountinhibit)
  );

  csr_counters u_counters (
    .CLK          (CLK),
    .nRST         (nRST),
    .csr_addr     (csr_addr),
    .commit       (commit),
    .wr_val       (wr_val.raw),
    .inst_ret     (inst_ret),
    .mcountinhibit(mcountinhibit),
    .mcycle_full  (mcycle_full),
    .minstret_full(minstret_full)
  );

  csr_read_mux #(
    .HART_ID(HART_ID)
  ) u_read_mux (
    .csr_addr     (csr_addr),
    .csr_write    (csr_write),
    .csr_set      (csr_set),
    .csr_clear    (csr_clear),
    .curr_priv    (curr_priv),
    .curr_mstatus (curr_mstatus),
    .curr_mtvec   (curr_mtvec),
    .curr_mie     (curr_mie),
    .curr_mip     (curr_mip),
    .curr_mepc    (curr_mepc),
    .curr_mcause  (curr_mcause),
    .mtval        (mtval),
    .mscratch     (mscratch),
    .mcounteren   (mcounteren),
    .mcountinhibit(mcountinhibit),
    .mcycle_full  (mcycle_full),
    .minstret_full(minstret_full),
    .mtime        (mtime),
    .read_val     (old_csr_val),
    .addr_fault   (addr_fault)
  );

endmodule

//--- testbench/csr_file_tb.sv
// Directed tests of the CSR file; inputs change on the falling edge and the run stops after 2000 cycles
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_file_tb import csr_pkg::*; ();

  localparam int WATCHDOG_CYCLES = 2000;  // Whole sequence is well under 400 cycles
  localparam int OP_WRITE = 0;
  localparam int OP_SET   = 1;
  localparam int OP_CLEAR = 2;
  localparam int OP_READ  = 3;  // Like csrrs with rs1 = x0

  logic                 CLK;
  logic                 nRST;
  logic [11:0]          csr_addr;
  logic                 csr_write;
  logic                 csr_set;
  logic                 csr_clear;
  logic                 csr_read_only;
  logic                 valid_write;
  logic [`CSR_XLEN-1:0] new_csr_val;
  priv_level_t          curr_priv;
  logic                 inst_ret;
  logic [63:0]          mtime;
  logic                 inject_mstatus;
  logic                 inject_mepc;
  logic                 inject_mcause;
  logic                 inject_mtval;
  logic                 inject_mip;
  csr_word_u            next_mstatus;
  logic [`CSR_XLEN-1:0] next_mepc;
  logic [`CSR_XLEN-1:0] next_mcause;
  logic [`CSR_XLEN-1:0] next_mtval;
  logic [`CSR_XLEN-1:0] next_mip;
  logic [`CSR_XLEN-1:0] old_csr_val;
  logic                 invalid_csr;
  logic [`CSR_XLEN-1:0] curr_mstatus;
  logic [`CSR_XLEN-1:0] curr_mtvec;
  logic [`CSR_XLEN-1:0] curr_mie;
  logic [`CSR_XLEN-1:0] curr_mip;
  logic [`CSR_XLEN-1:0] curr_mepc;
  logic [`CSR_XLEN-1:0] curr_mcause;

  logic [31:0] lfsr_state;
  int          pass_cnt;
  int          fail_cnt;

  csr_file #(.HART_ID(`CSR_HART_ID)) i_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] w);
    w = '0;
    for (int i = 0; i < n; i++) begin
      w = {w[30:0], lfsr_state[0]};  // One step per bit
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) pass_cnt++;
    else begin
      $display("CHECK FAILED at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
      fail_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    assert (act === exp) pass_cnt++;
    else begin
      $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      fail_cnt++;
    end
  endtask

  task automatic idle();
    csr_write     = 1'b0;
    csr_set       = 1'b0;
    csr_clear     = 1'b0;
    csr_read_only = 1'b0;
    valid_write   = 1'b0;
    new_csr_val   = '0;
    curr_priv     = M_MODE;
  endtask

  // One committing access; returns at the falling edge after the write edge
  task automatic csr_op(input logic [11:0] addr, input int op, input logic [31:0] val,
                        input priv_level_t priv, output logic [31:0] rd, output logic inv);
    @(negedge CLK);
    csr_addr      = addr;
    csr_write     = (op == OP_WRITE);
    csr_set       = (op == OP_SET) || (op == OP_READ);
    csr_clear     = (op == OP_CLEAR);
    csr_read_only = (op == OP_READ);
    valid_write   = 1'b1;
    new_csr_val   = (op == OP_READ) ? '0 : val;
    curr_priv     = priv;
    #2;
    rd  = old_csr_val;
    inv = invalid_csr;
    @(negedge CLK);
    idle();
  endtask

  // Read with no operation, one falling edge later
  task automatic peek(input logic [11:0] addr, output logic [31:0] val, output logic inv);
    @(negedge CLK);
    csr_addr = addr;
    #1;
    val = old_csr_val;
    inv = invalid_csr;
  endtask

  task automatic report_test(input string name, input int fails_before);
    if (fail_cnt == fails_before)
      $display("%s: ok", name);
    else
      $display("%s: %0d check(s) failed", name, fail_cnt - fails_before);
  endtask

  task automatic test_reset_values();
    int          fails_before;
    logic [31:0] v;
    logic        inv;
    fails_before = fail_cnt;
    peek(`CSR_MSTATUS_ADDR, v, inv);
    check("mstatus", 32'h0020_0000, v);
    check_flag("invalid_csr", 1'b0, inv);
    peek(`CSR_MCOUNTEREN_ADDR, v, inv);
    check("mcounteren", 32'd7, v);
    peek(`CSR_MISA_ADDR, v, inv);
    check("misa", `CSR_MISA_VALUE, v);
    peek(`CSR_MHARTID_ADDR, v, inv);
    check("mhartid", `CSR_HART_ID, v);
    peek(`CSR_MSTATUSH_ADDR, v, inv);
    check("mstatush", 32'h0, v);
    peek(`CSR_MVENDORID_ADDR, v, inv);
    check("mvendorid", 32'h0, v);
    check_flag("invalid_csr", 1'b0, inv);
    report_test("reset and constants", fails_before);
  endtask

  task automatic test_write_set_clear();
    int          fails_before;
    logic [31:0] a, b, v;
    logic        inv;
    fails_before = fail_cnt;
    rand_bits(32, a);
    rand_bits(32, b);
    csr_op(`CSR_MSCRATCH_ADDR, OP_WRITE, a, M_MODE, v, inv);
    peek(`CSR_MSCRATCH_ADDR, v, inv);
    check("mscratch after write", a, v);
    csr_op(`CSR_MSCRATCH_ADDR, OP_SET, b, M_MODE, v, inv);
    check("old_csr_val during set", a, v);
    peek(`CSR_MSCRATCH_ADDR, v, inv);
    check("mscratch after set", a | b, v);
    csr_op(`CSR_MSCRATCH_ADDR, OP_CLEAR, b, M_MODE, v, inv);
    peek(`CSR_MSCRATCH_ADDR, v, inv);
    check("mscratch after clear", (a | b) & ~b, v);
    report_test("write set clear", fails_before);
  endtask

  task automatic test_legalization();
    int          fails_before;
    logic [31:0] w, v;
    logic        inv;
    fails_before = fail_cnt;
    csr_op(`CSR_MSTATUS_ADDR, OP_WRITE, 32'h0000_0800, M_MODE, v, inv);  // mpp = S
    peek(`CSR_MSTATUS_ADDR, v, inv);
    check("mstatus.mpp from 1", 32'h0, {30'b0, v[12:11]});
    csr_op(`CSR_MSTATUS_ADDR, OP_WRITE, 32'h0000_1000, M_MODE, v, inv);
    peek(`CSR_MSTATUS_ADDR, v, inv);
    check("mstatus.mpp from 2", 32'h0, {30'b0, v[12:11]});
    csr_op(`CSR_MSTATUS_ADDR, OP_WRITE, 32'h0000_1800, M_MODE, v, inv);
    peek(`CSR_MSTATUS_ADDR, v, inv);
    check("mstatus.mpp from 3", 32'h3, {30'b0, v[12:11]});
    rand_bits(32, w);
    csr_op(`CSR_MTVEC_ADDR, OP_WRITE, {w[31:2], 2'b10}, M_MODE, v, inv);
    peek(`CSR_MTVEC_ADDR, v, inv);
    check("mtvec mode 2", {w[31:2], 2'b00}, v);
    csr_op(`CSR_MTVEC_ADDR, OP_WRITE, {w[31:2], 2'b11}, M_MODE, v, inv);
    peek(`CSR_MTVEC_ADDR, v, inv);
    check("mtvec mode 3", {w[31:2], 2'b00}, v);
    check("curr_mtvec", {w[31:2], 2'b00}, curr_mtvec);
    csr_op(`CSR_MIE_ADDR, OP_WRITE, 32'hFFFF_FFFF, M_MODE, v, inv);
    peek(`CSR_MIE_ADDR, v, inv);
    check("mie", `CSR_INT_MASK, v);
    check("curr_mie", `CSR_INT_MASK, curr_mie);
    report_test("legalization", fails_before);
  endtask

  task automatic test_faults();
    int          fails_before;
    logic [31:0] x, v;
    logic [11:0] bad_addr [2];
    logic        inv;
    fails_before = fail_cnt;
    bad_addr[0] = 12'h180;  // satp does not exist without supervisor mode
    bad_addr[1] = 12'h7C0;
    rand_bits(32, x);
    csr_op(`CSR_MSCRATCH_ADDR, OP_WRITE, x, M_MODE, v, inv);
    rand_bits(32, v);
    csr_op(`CSR_MSCRATCH_ADDR, OP_WRITE, v, U_MODE, v, inv);
    check_flag("invalid_csr (user mscratch)", 1'b1, inv);
    peek(`CSR_MSCRATCH_ADDR, v, inv);
    check("mscratch kept", x, v);
    csr_op(`CSR_MHARTID_ADDR, OP_WRITE, 32'hFFFF_FFFF, M_MODE, v, inv);
    check_flag("invalid_csr (mhartid write)", 1'b1, inv);
    peek(`CSR_MHARTID_ADDR, v, inv);
    check("mhartid kept", `CSR_HART_ID, v);
    for (int i = 0; i < 2; i++) begin
      for (int op = OP_WRITE; op <= OP_CLEAR; op++) begin
        csr_op(bad_addr[i], op, 32'hFFFF_FFFF, M_MODE, v, inv);
        check_flag("invalid_csr (unimplemented)", 1'b1, inv);
      end
    end
    peek(`CSR_MSCRATCH_ADDR, v, inv);
    check("mscratch kept", x, v);
    csr_op(`CSR_MCOUNTEREN_ADDR, OP_CLEAR, 32'h1, M_MODE, v, inv);  // Hide cycle from U
    csr_op(`CSR_CYCLE_ADDR, OP_READ, 32'h0, U_MODE, v, inv);
    check_flag("invalid_csr (cycle hidden)", 1'b1, inv);
    check("cycle read while hidden", 32'h0, v);
    csr_op(`CSR_MCOUNTEREN_ADDR, OP_SET, 32'h1, M_MODE, v, inv);
    csr_op(`CSR_CYCLE_ADDR, OP_READ, 32'h0, U_MODE, v, inv);
    check_flag("invalid_csr (cycle enabled)", 1'b0, inv);
    peek(`CSR_MCOUNTEREN_ADDR, v, inv);
    check("mcounteren", 32'd7, v);
    report_test("faults", fails_before);
  endtask

  task automatic test_counters();
    int          fails_before;
    logic [31:0] w, v, v0, n;
    logic [63:0] t;
    logic        inv;
    fails_before = fail_cnt;
    csr_op(`CSR_MCOUNTINHIBIT_ADDR, OP_WRITE, 32'h1, M_MODE, v, inv);  // Stop mcycle only
    rand_bits(32, w);
    csr_op(`CSR_MCYCLE_ADDR, OP_WRITE, w, M_MODE, v, inv);
    repeat (3) begin
      peek(`CSR_MCYCLE_ADDR, v, inv);
      check("mcycle while inhibited", w, v);
    end
    csr_op(`CSR_MCOUNTINHIBIT_ADDR, OP_WRITE, 32'h0, M_MODE, v, inv);
    rand_bits(4, n);
    n = n + 1;
    // First increment is at the edge after this falling edge
    repeat (n - 1) @(negedge CLK);
    peek(`CSR_MCYCLE_ADDR, v, inv);
    check("mcycle after uninhibit", w + n, v);

    peek(`CSR_MINSTRET_ADDR, v0, inv);
    rand_bits(4, n);
    n = n + 1;
    repeat (n) begin
      @(negedge CLK);
      inst_ret = 1'b1;
      @(negedge CLK);
      inst_ret = 1'b0;
    end
    peek(`CSR_MINSTRET_ADDR, v, inv);
    check("minstret", v0 + n, v);

    rand_bits(32, t[63:32]);
    rand_bits(32, t[31:0]);
    @(negedge CLK);
    mtime = t;
    peek(`CSR_TIME_ADDR, v, inv);
    check("time", t[31:0], v);
    peek(`CSR_TIMEH_ADDR, v, inv);
    check("timeh", t[63:32], v);
    report_test("counters", fails_before);
  endtask

  task automatic test_trap_inject();
    int          fails_before;
    logic [31:0] p, c, tv, v;
    logic        inv;
    fails_before = fail_cnt;
    rand_bits(32, p);
    rand_bits(32, c);
    rand_bits(32, tv);
    @(negedge CLK);
    next_mepc     = p;
    next_mcause   = c;
    next_mtval    = tv;
    inject_mepc   = 1'b1;
    inject_mcause = 1'b1;
    inject_mtval  = 1'b1;
    @(negedge CLK);
    inject_mepc   = 1'b0;
    inject_mcause = 1'b0;
    inject_mtval  = 1'b0;
    check("curr_mepc", p, curr_mepc);
    check("curr_mcause", c, curr_mcause);
    peek(`CSR_MTVAL_ADDR, v, inv);
    check("mtval", tv, v);

    // Software write and injection in the same cycle
    @(negedge CLK);
    csr_addr         = `CSR_MSTATUS_ADDR;
    csr_write        = 1'b1;
    valid_write      = 1'b1;
    new_csr_val      = 32'h0020_0008;
    next_mstatus.raw = 32'h0000_1888;  // mie, mpie, mpp = M
    inject_mstatus   = 1'b1;
    @(negedge CLK);
    idle();
    inject_mstatus = 1'b0;
    check("curr_mstatus", 32'h0000_1888, curr_mstatus);

    @(negedge CLK);
    next_mip   = 32'h0000_0880;
    inject_mip = 1'b1;
    @(negedge CLK);
    inject_mip = 1'b0;
    check("curr_mip", 32'h0000_0880, curr_mip);
    report_test("trap injection", fails_before);
  endtask

  initial begin
    lfsr_state       = 32'd3516;
    pass_cnt         = 0;
    fail_cnt         = 0;
    nRST             = 1'b0;
    csr_addr         = '0;
    inst_ret         = 1'b0;
    mtime            = '0;
    inject_mstatus   = 1'b0;
    inject_mepc      = 1'b0;
    inject_mcause    = 1'b0;
    inject_mtval     = 1'b0;
    inject_mip       = 1'b0;
    next_mstatus.raw = '0;
    next_mepc        = '0;
    next_mcause      = '0;
    next_mtval       = '0;
    next_mip         = '0;
    idle();
    repeat (8) @(negedge CLK);
    nRST = 1'b1;

    test_reset_values();
    test_write_set_clear();
    test_legalization();
    test_faults();
    test_counters();
    test_trap_inject();

    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Run timed out after %0d cycles before all tests finished", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- tb.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_access.sv
hdl/csr_trap_regs.sv
hdl/csr_counters.sv
hdl/csr_read_mux.sv
hdl/csr_file.sv
testbench/csr_file_tb.sv

//--- Makefile
TOP = csr_file_tb

.PHONY: build run clean

build:
	verilator --binary --assert --timescale 1ns/100ps --top-module $(TOP) -f tb.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
